// ==== tag_dir_pkg.sv ====
// tag directory package.
// geometry of the four-way, 128-set tag directory, the layout of a stored
// entry and the enums shared by the controller and the testbench.

package tag_dir_pkg;

  // --------------------------------------------------------------------------
  // geometry
  // --------------------------------------------------------------------------

  // the low bits of a line address pick the set.
  localparam int set_bits = 7;
  localparam int num_sets = 128;

  // the remaining upper bits form the stored tag.
  localparam int tag_bits = 17;
  localparam int line_bits = 24;

  localparam int num_ways = 4;
  localparam int way_bits = 2;

  // one 3-bit tree per set for the pseudo-LRU choice.
  localparam int plru_bits = 3;

  // --------------------------------------------------------------------------
  // entry layout
  // --------------------------------------------------------------------------

  // an entry is {valid, tag, parity}, with the parity bit chosen so that
  // the whole entry has even parity.
  localparam int entry_bits = 19;

  // --------------------------------------------------------------------------
  // enums
  // --------------------------------------------------------------------------

  // command encoding, carried on the Wishbone address of a write.
  typedef enum logic [1:0] {
    cmd_lookup     = 2'd0,
    cmd_fill       = 2'd1,
    cmd_invalidate = 2'd2
  } tag_cmd_e;

  typedef enum logic [2:0] {
    idle,
    init_sweep,
    read_wait,
    compare,
    respond
  } ctrl_state_e;

endpackage

// ==== tag_way_if.sv ====
// tag way interface.
// carries the read and write-back requests from the controller to one way
// and the lookup result back. results are valid one cycle after rd_en.

interface tag_way_if;

  // requests from the controller.
  logic                             rd_en;
  logic [tag_dir_pkg::set_bits-1:0] rd_index;
  logic [tag_dir_pkg::tag_bits-1:0] cmp_tag;
  logic                             wr_en;
  logic [tag_dir_pkg::set_bits-1:0] wr_index;
  logic                             wr_clear;

  // lookup result from the way.
  logic                             hit;
  logic                             entry_valid;
  logic [tag_dir_pkg::tag_bits-1:0] entry_tag;
  logic                             parity_err;

  modport ctrl (
    output rd_en, rd_index, cmp_tag, wr_en, wr_index, wr_clear,
    input  hit, entry_valid, entry_tag, parity_err
  );

  modport way (
    input  rd_en, rd_index, cmp_tag, wr_en, wr_index, wr_clear,
    output hit, entry_valid, entry_tag, parity_err
  );

endinterface

// ==== tag_ram.sv ====
// tag RAM.
// single read port and single write port synchronous RAM. the read address
// is registered and the array is read at the held address.

module tag_ram #(
  parameter int width = tag_dir_pkg::entry_bits,
  parameter int depth = tag_dir_pkg::num_sets
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rd_en,
  input  logic [$clog2(depth)-1:0] rd_addr,
  output logic [width-1:0]         rd_data,
  input  logic                     wr_en,
  input  logic [$clog2(depth)-1:0] wr_addr,
  input  logic [width-1:0]         wr_data
);

  logic [width-1:0]         mem [depth];
  logic [$clog2(depth)-1:0] rd_addr_q;

  // the output follows writes to the held address in the next cycle.
  assign rd_data = mem[rd_addr_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q <= '0;
    end else if (rd_en) begin
      rd_addr_q <= rd_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

// ==== tag_way.sv ====
// tag way.
// one way of tag storage. builds and writes entries with even parity,
// checks the parity of the entry read back and compares its tag with the
// tag held by the controller.

module tag_way (
  input  logic   clk,
  input  logic   rst,
  tag_way_if.way bus
);

  logic [tag_dir_pkg::entry_bits-1:0] rd_entry;
  logic [tag_dir_pkg::entry_bits-1:0] new_entry;
  logic [tag_dir_pkg::entry_bits-1:0] wr_entry;
  logic                               new_parity;
  logic                               stored_valid;
  logic [tag_dir_pkg::tag_bits-1:0]   stored_tag;
  logic                               parity_ok;

  // --------------------------------------------------------------------------
  // write side
  // --------------------------------------------------------------------------

  // the parity bit makes the xor over the whole entry zero.
  assign new_parity = ^{1'b1, bus.cmp_tag};
  assign new_entry  = {1'b1, bus.cmp_tag, new_parity};

  // clearing writes all zero, which also has even parity.
  assign wr_entry = bus.wr_clear ? '0 : new_entry;

  tag_ram #(
    .width (tag_dir_pkg::entry_bits),
    .depth (tag_dir_pkg::num_sets)
  ) ram_i (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (bus.rd_en),
    .rd_addr (bus.rd_index),
    .rd_data (rd_entry),
    .wr_en   (bus.wr_en),
    .wr_addr (bus.wr_index),
    .wr_data (wr_entry)
  );

  // --------------------------------------------------------------------------
  // read side
  // --------------------------------------------------------------------------

  assign stored_valid = rd_entry[tag_dir_pkg::entry_bits-1];
  assign stored_tag   = rd_entry[tag_dir_pkg::entry_bits-2:1];
  assign parity_ok    = ~^rd_entry;

  // an entry with bad parity never hits, so the line is refetched.
  assign bus.hit         = stored_valid && parity_ok && (stored_tag == bus.cmp_tag);
  assign bus.entry_valid = stored_valid;
  assign bus.entry_tag   = stored_tag;
  assign bus.parity_err  = stored_valid && !parity_ok;

endmodule

// ==== plru_tree.sv ====
// tree pseudo-LRU.
// keeps three replacement bits per set. bit 0 picks the half to victimize,
// bits 1 and 2 pick the way inside the lower and upper half.

module plru_tree (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             rd_en,
  input  logic [tag_dir_pkg::set_bits-1:0] rd_index,
  input  logic                             upd_en,
  input  logic [tag_dir_pkg::set_bits-1:0] upd_index,
  input  logic [tag_dir_pkg::way_bits-1:0] access_way,
  input  logic                             init_en,
  output logic [tag_dir_pkg::way_bits-1:0] victim
);

  logic [tag_dir_pkg::plru_bits-1:0] cur_bits;
  logic [tag_dir_pkg::plru_bits-1:0] next_bits;
  logic [tag_dir_pkg::plru_bits-1:0] wr_bits;

  tag_ram #(
    .width (tag_dir_pkg::plru_bits),
    .depth (tag_dir_pkg::num_sets)
  ) ram_i (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (rd_en),
    .rd_addr (rd_index),
    .rd_data (cur_bits),
    .wr_en   (upd_en || init_en),
    .wr_addr (upd_index),
    .wr_data (wr_bits)
  );

  // an access points the tree away from the way just used.
  // only the root and the bit of the accessed half change.
  always_comb begin
    next_bits = cur_bits;
    case (access_way)
      2'd0: begin
        next_bits[0] = 1'b1;
        next_bits[1] = 1'b1;
      end
      2'd1: begin
        next_bits[0] = 1'b1;
        next_bits[1] = 1'b0;
      end
      2'd2: begin
        next_bits[0] = 1'b0;
        next_bits[2] = 1'b1;
      end
      default: begin
        next_bits[0] = 1'b0;
        next_bits[2] = 1'b0;
      end
    endcase
  end

  assign wr_bits = init_en ? '0 : next_bits;

  // a set bit in a half means its lower way was used last.
  assign victim = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};

endmodule

// ==== tag_dir_ctrl.sv ====
// tag directory controller.
// Wishbone classic slave that clears all sets after reset, then runs one
// command at a time: read the ways, register the compare result, write back
// and ack. status and evicted line address are readable registers.

module tag_dir_ctrl (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             cyc,
  input  logic                             stb,
  input  logic                             we,
  input  logic [1:0]                       adr,
  input  logic [31:0]                      dat_w,
  output logic [31:0]                      dat_r,
  output logic                             ack,
  tag_way_if.ctrl                          ways [tag_dir_pkg::num_ways],
  output logic                             plru_rd_en,
  output logic [tag_dir_pkg::set_bits-1:0] plru_rd_index,
  output logic                             plru_upd_en,
  output logic [tag_dir_pkg::set_bits-1:0] plru_upd_index,
  output logic [tag_dir_pkg::way_bits-1:0] plru_access_way,
  output logic                             plru_init_en,
  input  logic [tag_dir_pkg::way_bits-1:0] victim
);

  tag_dir_pkg::ctrl_state_e             state_q;
  tag_dir_pkg::tag_cmd_e                cmd_q;
  logic [tag_dir_pkg::set_bits-1:0]     sweep_q;
  logic [tag_dir_pkg::line_bits-1:0]    line_q;
  logic [tag_dir_pkg::set_bits-1:0]     set_idx;
  logic                                 sweeping;
  logic                                 accept_wr;
  logic                                 accept_rd;
  logic                                 rd_pend_q;
  logic                                 do_write;
  logic [tag_dir_pkg::num_ways-1:0]     wr_sel;

  // way results as seen by the ports and as registered one cycle later.
  logic [tag_dir_pkg::num_ways-1:0]     hit_w;
  logic [tag_dir_pkg::num_ways-1:0]     valid_w;
  logic [tag_dir_pkg::num_ways-1:0]     perr_w;
  logic [tag_dir_pkg::tag_bits-1:0]     tag_w [tag_dir_pkg::num_ways];
  logic [tag_dir_pkg::num_ways-1:0]     hit_q;
  logic [tag_dir_pkg::num_ways-1:0]     valid_q;
  logic                                 perr_q;
  logic [tag_dir_pkg::tag_bits-1:0]     tag_q [tag_dir_pkg::num_ways];
  logic [tag_dir_pkg::way_bits-1:0]     victim_q;

  // compare result.
  logic [tag_dir_pkg::way_bits-1:0]     pick_way;
  logic                                 any_hit;
  logic                                 evict;
  logic [tag_dir_pkg::way_bits-1:0]     sel_way_q;
  logic                                 any_hit_q;
  logic [4:0]                           status_q;
  logic [tag_dir_pkg::line_bits-1:0]    evict_q;

  assign sweeping  = (state_q == tag_dir_pkg::init_sweep);
  assign accept_wr = (state_q == tag_dir_pkg::idle) && cyc && stb && we && !ack && !rd_pend_q;
  assign accept_rd = (state_q == tag_dir_pkg::idle) && cyc && stb && !we && !ack && !rd_pend_q;
  assign set_idx   = sweeping ? sweep_q : line_q[tag_dir_pkg::set_bits-1:0];

  // --------------------------------------------------------------------------
  // way and replacement requests
  // --------------------------------------------------------------------------

  // invalidate only writes when the line was found.
  assign do_write = (cmd_q == tag_dir_pkg::cmd_fill) ||
                    ((cmd_q == tag_dir_pkg::cmd_invalidate) && any_hit_q);
  assign wr_sel   = sweeping ? '1 :
                    ((state_q == tag_dir_pkg::respond) && do_write) ? (4'b0001 << sel_way_q) :
                    '0;

  for (genvar g = 0; g < tag_dir_pkg::num_ways; g++) begin : g_way
    assign ways[g].rd_en    = accept_wr;
    assign ways[g].rd_index = dat_w[tag_dir_pkg::set_bits-1:0];
    assign ways[g].cmp_tag  = line_q[tag_dir_pkg::line_bits-1:tag_dir_pkg::set_bits];
    assign ways[g].wr_en    = wr_sel[g];
    assign ways[g].wr_index = set_idx;
    assign ways[g].wr_clear = sweeping || (cmd_q == tag_dir_pkg::cmd_invalidate);
    assign hit_w[g]         = ways[g].hit;
    assign valid_w[g]       = ways[g].entry_valid;
    assign perr_w[g]        = ways[g].parity_err;
    assign tag_w[g]         = ways[g].entry_tag;
  end

  assign plru_rd_en      = accept_wr;
  assign plru_rd_index   = dat_w[tag_dir_pkg::set_bits-1:0];
  assign plru_upd_index  = set_idx;
  assign plru_access_way = sel_way_q;
  assign plru_init_en    = sweeping;
  assign plru_upd_en     = (state_q == tag_dir_pkg::respond) &&
                           ((cmd_q == tag_dir_pkg::cmd_fill) ||
                            ((cmd_q == tag_dir_pkg::cmd_lookup) && any_hit_q));

  // --------------------------------------------------------------------------
  // way selection
  // --------------------------------------------------------------------------

  // the first hit wins, then the lowest invalid way, then the tree victim.
  always_comb begin
    pick_way = victim_q;
    for (int i = tag_dir_pkg::num_ways - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        pick_way = i[tag_dir_pkg::way_bits-1:0];
      end
    end
    for (int i = tag_dir_pkg::num_ways - 1; i >= 0; i--) begin
      if (hit_q[i]) begin
        pick_way = i[tag_dir_pkg::way_bits-1:0];
      end
    end
  end

  assign any_hit = |hit_q;
  assign evict   = (cmd_q == tag_dir_pkg::cmd_fill) && !any_hit && valid_q[pick_way];

  // --------------------------------------------------------------------------
  // state machine and result registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= tag_dir_pkg::init_sweep;
      sweep_q   <= '0;
      ack       <= 1'b0;
      rd_pend_q <= 1'b0;
      status_q  <= '0;
      evict_q   <= '0;
    end else begin
      ack <= 1'b0;
      case (state_q)
        tag_dir_pkg::init_sweep: begin
          sweep_q <= sweep_q + 1'b1;
          if (&sweep_q) begin
            state_q <= tag_dir_pkg::idle;
          end
        end
        tag_dir_pkg::idle: begin
          if (accept_wr) begin
            state_q <= tag_dir_pkg::read_wait;
          end
          // a register read is answered in the cycle after it is accepted.
          if (accept_rd) begin
            rd_pend_q <= 1'b1;
          end
          if (rd_pend_q) begin
            rd_pend_q <= 1'b0;
            ack       <= 1'b1;
          end
        end
        tag_dir_pkg::read_wait: state_q <= tag_dir_pkg::compare;
        tag_dir_pkg::compare: begin
          state_q  <= tag_dir_pkg::respond;
          // a miss other than a fill reports way 0.
          status_q <= {perr_q, evict,
                       (any_hit || cmd_q == tag_dir_pkg::cmd_fill) ? pick_way : 2'd0,
                       any_hit};
          evict_q  <= evict ? {tag_q[pick_way], line_q[tag_dir_pkg::set_bits-1:0]} : '0;
        end
        tag_dir_pkg::respond: begin
          state_q <= tag_dir_pkg::idle;
          ack     <= 1'b1;
        end
        default: state_q <= tag_dir_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept_wr) begin
      line_q <= dat_w[tag_dir_pkg::line_bits-1:0];
      cmd_q  <= tag_dir_pkg::tag_cmd_e'(adr);
    end
    if (state_q == tag_dir_pkg::read_wait) begin
      hit_q    <= hit_w;
      valid_q  <= valid_w;
      perr_q   <= |perr_w;
      tag_q    <= tag_w;
      victim_q <= victim;
    end
    if (state_q == tag_dir_pkg::compare) begin
      sel_way_q <= pick_way;
      any_hit_q <= any_hit;
    end
    if (rd_pend_q) begin
      dat_r <= (adr == 2'd0) ? 32'(status_q) :
               (adr == 2'd1) ? 32'(evict_q) : 32'd0;
    end
  end

endmodule

// ==== tag_dir_top.sv ====
// tag directory top level.
// four tag ways and the pseudo-LRU tree behind a Wishbone classic slave
// with plain ports.

module tag_dir_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [1:0]  adr,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack
);

  logic                             plru_rd_en;
  logic [tag_dir_pkg::set_bits-1:0] plru_rd_index;
  logic                             plru_upd_en;
  logic [tag_dir_pkg::set_bits-1:0] plru_upd_index;
  logic [tag_dir_pkg::way_bits-1:0] plru_access_way;
  logic                             plru_init_en;
  logic [tag_dir_pkg::way_bits-1:0] victim;

  tag_way_if way_bus [tag_dir_pkg::num_ways] ();

  tag_dir_ctrl ctrl_i (
    .clk             (clk),
    .rst             (rst),
    .cyc             (cyc),
    .stb             (stb),
    .we              (we),
    .adr             (adr),
    .dat_w           (dat_w),
    .dat_r           (dat_r),
    .ack             (ack),
    .ways            (way_bus),
    .plru_rd_en      (plru_rd_en),
    .plru_rd_index   (plru_rd_index),
    .plru_upd_en     (plru_upd_en),
    .plru_upd_index  (plru_upd_index),
    .plru_access_way (plru_access_way),
    .plru_init_en    (plru_init_en),
    .victim          (victim)
  );

  for (genvar g = 0; g < tag_dir_pkg::num_ways; g++) begin : g_way
    tag_way way_i (
      .clk (clk),
      .rst (rst),
      .bus (way_bus[g])
    );
  end

  plru_tree plru_i (
    .clk        (clk),
    .rst        (rst),
    .rd_en      (plru_rd_en),
    .rd_index   (plru_rd_index),
    .upd_en     (plru_upd_en),
    .upd_index  (plru_upd_index),
    .access_way (plru_access_way),
    .init_en    (plru_init_en),
    .victim     (victim)
  );

endmodule

// ==== tag_dir_assertions.sv ====
// Wishbone handshake checks for the tag directory controller.
// bound into tag_dir_ctrl. keeps ack a single pulse that answers a strobe
// and holds it low during the init sweep.

module tag_dir_assertions (
  input logic                     clk,
  input logic                     rst,
  input logic                     cyc,
  input logic                     stb,
  input logic                     ack,
  input tag_dir_pkg::ctrl_state_e state_q
);

  int fail_count = 0;

  // ack is a one-cycle pulse, even while the master still holds stb.
  ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
    ack |=> !ack)
  else begin
    $error("ack stayed high for two cycles");
    fail_count = fail_count + 1;
  end

  ack_needs_strobe: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(cyc && stb))
  else begin
    $error("ack rose without cyc and stb");
    fail_count = fail_count + 1;
  end

  ack_low_in_sweep: assert property (@(posedge clk) disable iff (rst)
    (state_q == tag_dir_pkg::init_sweep) |-> !ack)
  else begin
    $error("ack high during the init sweep");
    fail_count = fail_count + 1;
  end

endmodule

bind tag_dir_ctrl tag_dir_assertions assertions_i (
  .clk     (clk),
  .rst     (rst),
  .cyc     (cyc),
  .stb     (stb),
  .ack     (ack),
  .state_q (state_q)
);

// ==== tb_tag_dir.sv ====
// testbench for the tag directory.
// drives lookup, fill and invalidate commands over Wishbone, reads back the
// status word and the evicted address and checks both against a model of
// the tag array and the tree pseudo-LRU state.

module tb_tag_dir;

  localparam int num_random = 300;
  localparam int max_cmds   = num_random + 32;
  localparam int xfer_limit = 400;
  // each command is a write and two reads, each well under eight cycles.
  localparam int watchdog_cycles = tag_dir_pkg::num_sets + 8 * 3 * max_cmds + 500;

  logic        clk;
  logic        rst;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [1:0]  adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;
  integer      seed;

  // reference model of the directory.
  logic                             ref_valid [tag_dir_pkg::num_sets][tag_dir_pkg::num_ways];
  logic [tag_dir_pkg::tag_bits-1:0] ref_tag [tag_dir_pkg::num_sets][tag_dir_pkg::num_ways];
  logic [2:0]                       ref_plru [tag_dir_pkg::num_sets];

  tag_dir_top tag_dir_top_i (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  always #10 clk = ~clk;

  // --------------------------------------------------------------------------
  // address pool and replacement model
  // --------------------------------------------------------------------------

  // sixteen tags over eight sets spread across the index range.
  function automatic logic [tag_dir_pkg::line_bits-1:0] make_line(input int t, input int s);
    logic [tag_dir_pkg::tag_bits-1:0] tag;
    logic [tag_dir_pkg::set_bits-1:0] set;
    tag = 17'(t * 419 + 2748);
    set = 7'(s * 16 + 5);
    return {tag, set};
  endfunction

  function automatic logic [1:0] tree_victim(input logic [2:0] bits);
    if (!bits[0]) begin
      return bits[1] ? 2'd1 : 2'd0;
    end
    return bits[2] ? 2'd3 : 2'd2;
  endfunction

  function automatic logic [2:0] tree_touch(input logic [2:0] bits, input logic [1:0] way);
    logic [2:0] r;
    r = bits;
    if (way < 2'd2) begin
      r[0] = 1'b1;
      r[1] = (way == 2'd0);
    end else begin
      r[0] = 1'b0;
      r[2] = (way == 2'd2);
    end
    return r;
  endfunction

  task automatic model_cmd(input tag_dir_pkg::tag_cmd_e cmd,
                           input logic [tag_dir_pkg::line_bits-1:0] line,
                           output logic [31:0] exp_status, output logic [31:0] exp_evict);
    logic [tag_dir_pkg::set_bits-1:0] s;
    logic [tag_dir_pkg::tag_bits-1:0] t;
    logic                             hit;
    logic                             evict;
    logic [1:0]                       way;
    s = line[tag_dir_pkg::set_bits-1:0];
    t = line[tag_dir_pkg::line_bits-1:tag_dir_pkg::set_bits];
    hit = 1'b0;
    evict = 1'b0;
    way = 2'd0;
    exp_evict = 32'd0;
    for (int i = 3; i >= 0; i--) begin
      if (ref_valid[s][i] && ref_tag[s][i] == t) begin
        hit = 1'b1;
        way = 2'(i);
      end
    end
    case (cmd)
      tag_dir_pkg::cmd_lookup: begin
        if (hit) begin
          ref_plru[s] = tree_touch(ref_plru[s], way);
        end
      end
      tag_dir_pkg::cmd_fill: begin
        if (!hit) begin
          way = tree_victim(ref_plru[s]);
          for (int i = 3; i >= 0; i--) begin
            if (!ref_valid[s][i]) begin
              way = 2'(i);
            end
          end
          evict = ref_valid[s][way];
          if (evict) begin
            exp_evict = 32'({ref_tag[s][way], s});
          end
        end
        ref_valid[s][way] = 1'b1;
        ref_tag[s][way] = t;
        ref_plru[s] = tree_touch(ref_plru[s], way);
      end
      default: begin
        if (hit) begin
          ref_valid[s][way] = 1'b0;
        end
      end
    endcase
    exp_status = {27'd0, 1'b0, evict, way, hit};
  endtask

  // --------------------------------------------------------------------------
  // bus access and checks
  // --------------------------------------------------------------------------

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // latency counts the cycles from the edge that samples stb to ack.
  task automatic bus_xfer(input logic write, input logic [1:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output int latency);
    int n;
    n = 0;
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    we = write;
    adr = addr;
    dat_w = wdata;
    while (!ack && n < xfer_limit) begin
      @(posedge clk);
      n++;
      @(negedge clk);
    end
    assert (ack) else begin
      $display("the DUT gave no ack within %0d cycles at time %0t", xfer_limit, $time);
      $display("TEST RESULT: FAIL");
      $fatal(1, "bus transfer timed out");
    end
    rdata = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = 2'd0;
    dat_w = 32'd0;
    latency = n - 1;
  endtask

  task automatic run_cmd(input tag_dir_pkg::tag_cmd_e cmd,
                         input logic [tag_dir_pkg::line_bits-1:0] line,
                         input bit after_reset, output logic [31:0] status);
    logic [31:0] exp_status;
    logic [31:0] exp_evict;
    logic [31:0] got;
    int          lat;
    model_cmd(cmd, line, exp_status, exp_evict);
    bus_xfer(1'b1, 2'(cmd), 32'(line), got, lat);
    if (after_reset) begin
      assert (lat >= tag_dir_pkg::num_sets) else begin
        $display("MISMATCH at time %0t: first command acked after %0d cycles", $time, lat);
        $display("TEST RESULT: FAIL");
        $fatal(1, "command did not wait for the init sweep");
      end
    end else begin
      check_value("write ack latency", 32'(lat), 32'd3);
    end
    bus_xfer(1'b0, 2'd0, 32'd0, status, lat);
    check_value("status read ack latency", 32'(lat), 32'd1);
    check_value("parity error bit", 32'(status[4]), 32'd0);
    check_value("status word", status, exp_status);
    bus_xfer(1'b0, 2'd1, 32'd0, got, lat);
    check_value("evict read ack latency", 32'(lat), 32'd1);
    check_value("evicted line address", got, exp_evict);
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  initial begin
    logic [31:0]           status;
    logic [31:0]           r;
    logic [1:0]            fill_way;
    tag_dir_pkg::tag_cmd_e cmd;
    clk = 1'b0;
    rst = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = 2'd0;
    dat_w = 32'd0;
    seed = 32'hadbe82cf;
    for (int s = 0; s < tag_dir_pkg::num_sets; s++) begin
      ref_plru[s] = 3'd0;
      for (int w = 0; w < tag_dir_pkg::num_ways; w++) begin
        ref_valid[s][w] = 1'b0;
        ref_tag[s][w] = '0;
      end
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // the first command waits out the sweep and misses.
    run_cmd(tag_dir_pkg::cmd_lookup, make_line(3, 6), 1'b1, status);

    // an empty set takes ways 0 to 3 in order; each line then hits.
    for (int i = 0; i < 4; i++) begin
      run_cmd(tag_dir_pkg::cmd_fill, make_line(i, 2), 1'b0, status);
      check_value("way of fill into empty set", 32'(status[2:1]), 32'(i));
      check_value("evict flag of fill into free way", 32'(status[3]), 32'd0);
      fill_way = status[2:1];
      run_cmd(tag_dir_pkg::cmd_lookup, make_line(i, 2), 1'b0, status);
      check_value("lookup way after fill", 32'(status[2:1]), 32'(fill_way));
    end

    // a fifth tag evicts the tree victim, then invalidate removes it.
    run_cmd(tag_dir_pkg::cmd_fill, make_line(4, 2), 1'b0, status);
    check_value("evict flag of fill into full set", 32'(status[3]), 32'd1);
    run_cmd(tag_dir_pkg::cmd_invalidate, make_line(4, 2), 1'b0, status);
    check_value("hit of invalidate on present line", 32'(status[0]), 32'd1);
    run_cmd(tag_dir_pkg::cmd_lookup, make_line(4, 2), 1'b0, status);
    check_value("hit of lookup after invalidate", 32'(status[0]), 32'd0);
    run_cmd(tag_dir_pkg::cmd_invalidate, make_line(4, 2), 1'b0, status);
    check_value("hit of invalidate on absent line", 32'(status[0]), 32'd0);

    // random mix, weighted towards fills.
    for (int k = 0; k < num_random; k++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0: cmd = tag_dir_pkg::cmd_lookup;
        2'd2: cmd = tag_dir_pkg::cmd_invalidate;
        default: cmd = tag_dir_pkg::cmd_fill;
      endcase
      run_cmd(cmd, make_line(int'(r[7:4]), int'(r[10:8])), 1'b0, status);
    end

    if (tag_dir_top_i.ctrl_i.assertions_i.fail_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("bound assertions failed %0d times", tag_dir_top_i.ctrl_i.assertions_i.fail_count);
      $display("TEST RESULT: FAIL");
      $fatal(1, "assertion failures");
    end
  end

  // a failed handshake assertion ends the run at once.
  initial begin
    wait (tag_dir_top_i.ctrl_i.assertions_i.fail_count != 0);
    $display("a bound assertion failed at time %0t", $time);
    $display("TEST RESULT: FAIL");
    $fatal(1, "assertion failure");
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog timeout");
  end

endmodule

// ==== src.f ====
tag_dir_pkg.sv
tag_way_if.sv
tag_ram.sv
tag_way.sv
plru_tree.sv
tag_dir_ctrl.sv
tag_dir_top.sv
tag_dir_assertions.sv
tb_tag_dir.sv
